// File: output_port_config.svh
`ifndef OUTPUT_PORT_CONFIG_SVH
`define OUTPUT_PORT_CONFIG_SVH

////////////////////////////////////////
// network side field widths
////////////////////////////////////////

// destination leaf id
`define OP_LEAF_BITS 6
// destination port on that leaf
`define OP_PORT_BITS 4
// remote fifo address, also sized for the credit count
`define OP_ADDR_BITS 7
// full packet as it leaves the port
`define OP_PACKET_BITS 97

////////////////////////////////////////
// port side widths and depths
////////////////////////////////////////

// one word from the user stream
`define OP_USER_BITS 32
// two user words packed together
`define OP_PAYLOAD_BITS 64
// local buffer address, 128 entries
`define OP_FIFO_ADDR_BITS 7
`define OP_FIFO_DEPTH (1 << `OP_FIFO_ADDR_BITS)
// credits returned per add request
`define OP_FREESPACE_BLOCK 64
// statistics counter width
`define OP_STAT_BITS 64

// padding between header and address, 15 bits
`define OP_RESERVED_BITS \
    (`OP_PACKET_BITS - 1 - `OP_LEAF_BITS - `OP_PORT_BITS - `OP_ADDR_BITS - `OP_PAYLOAD_BITS)

`endif

// File: noc_pkg.sv
`default_nettype none

`include "output_port_config.svh"

package noc_pkg;

    ////////////////////////////////////////
    // routing fields
    ////////////////////////////////////////

    // leaf id in the fat tree
    typedef logic [`OP_LEAF_BITS-1:0] leaf_t;

    // port on the destination leaf
    typedef logic [`OP_PORT_BITS-1:0] port_t;

    // slot in the remote fifo, same width as credit count
    typedef logic [`OP_ADDR_BITS-1:0] fifo_addr_t;

    // where the stream is headed
    typedef struct packed {
        leaf_t dst_leaf;
        port_t dst_port;
    } dest_t;

    ////////////////////////////////////////
    // packet on the network side
    ////////////////////////////////////////

    // msb first, 97 bits total
    typedef struct packed {
        logic                           valid;
        leaf_t                          dst_leaf;
        port_t                          dst_port;
        // always zero here
        logic [`OP_RESERVED_BITS-1:0]   reserved;
        fifo_addr_t                     fifo_addr;
        logic [`OP_PAYLOAD_BITS-1:0]    payload;
    } packet_t;

endpackage

`default_nettype wire

// File: port_pkg.sv
`default_nettype none

`include "output_port_config.svh"

package port_pkg;

    ////////////////////////////////////////
    // data on the user side
    ////////////////////////////////////////

    // one word from the user stream
    typedef logic [`OP_USER_BITS-1:0] user_word_t;

    // pair of user words, first word in the low half
    typedef logic [`OP_PAYLOAD_BITS-1:0] payload_t;

    // free running event counter
    typedef logic [`OP_STAT_BITS-1:0] stat_t;

    ////////////////////////////////////////
    // control from the network side
    ////////////////////////////////////////

    // credit updates for the remote fifo
    typedef struct packed {
        // load freespace as the new count
        logic                       update_freespace_en;
        logic [`OP_ADDR_BITS-1:0]   freespace;
        // return one block of credits
        logic                       add_freespace_en;
    } credit_ctrl_t;

    // remote write address setup
    typedef struct packed {
        // load fifo_addr as the next address
        logic                       update_fifo_addr_en;
        logic [`OP_ADDR_BITS-1:0]   fifo_addr;
    } addr_ctrl_t;

endpackage

`default_nettype wire

// File: user_word_packer.sv
`timescale 1ns/100ps
`default_nettype none

module user_word_packer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 user_valid,
    input  port_pkg::user_word_t user_word,
    input  logic                 done_mode,
    input  logic                 full,
    output logic                 ack,
    output logic                 wr_en,
    output port_pkg::payload_t   wr_payload,
    output port_pkg::stat_t      full_cnt,
    output logic                 stall
);
    import port_pkg::*;

    // first word of the pair in progress
    user_word_t low_half;
    // low half already held, next word completes the pair
    logic       high_next;
    // word taken this cycle
    logic       accept;

    ////////////////////////////////////////
    // user handshake
    ////////////////////////////////////////

    // ready whenever the buffer has room
    assign ack = ~full;
    assign accept = user_valid & ack;

    // write on the second word, same edge it is taken
    assign wr_en = accept & high_next;
    assign wr_payload = payload_t'({user_word, low_half});

    // hold the first word
    always_ff @(posedge clk) begin
        if (accept && !high_next) begin
            low_half <= user_word;
        end
    end

    // toggle per accepted word
    always_ff @(posedge clk) begin
        if (reset) begin
            high_next <= 1'b0;
        end else if (accept) begin
            high_next <= ~high_next;
        end
    end

    ////////////////////////////////////////
    // statistics
    ////////////////////////////////////////

    // user has data but buffer is full
    assign stall = !done_mode && user_valid && full;

    // cycles spent full, not counted in done mode
    always_ff @(posedge clk) begin
        if (reset) begin
            full_cnt <= '0;
        end else if (full && !done_mode) begin
            full_cnt <= full_cnt + stat_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: payload_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "output_port_config.svh"

module payload_fifo (
    input  logic               clk,
    input  logic               reset,
    input  logic               wr_en,
    input  port_pkg::payload_t wr_payload,
    input  logic               rd_en,
    output port_pkg::payload_t rd_payload,
    output logic               full,
    output logic               empty
);
    import port_pkg::*;

    localparam int AW    = `OP_FIFO_ADDR_BITS;
    localparam int DEPTH = `OP_FIFO_DEPTH;

    // payload storage
    payload_t    mem [DEPTH];

    // extra msb tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    // each side sees the other pointer one cycle late
    logic [AW:0] wr_ptr_seen;
    logic [AW:0] rd_ptr_seen;

    ////////////////////////////////////////
    // write side
    ////////////////////////////////////////

    // producer only writes while full is low
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= wr_payload;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    ////////////////////////////////////////
    // read side
    ////////////////////////////////////////

    // read data register holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_payload <= mem[rd_ptr[AW-1:0]];
        end
    end

    // consumer gates rd_en with empty already
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    ////////////////////////////////////////
    // flags
    ////////////////////////////////////////

    // delayed copies bring a write to empty and a read to full
    // one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_seen <= '0;
            rd_ptr_seen <= '0;
        end else begin
            wr_ptr_seen <= wr_ptr;
            rd_ptr_seen <= rd_ptr;
        end
    end

    // own pointer is current so both flags err on the safe side
    assign full  = (wr_ptr[AW-1:0] == rd_ptr_seen[AW-1:0]) && (wr_ptr[AW] != rd_ptr_seen[AW]);
    assign empty = (rd_ptr == wr_ptr_seen);

endmodule

`default_nettype wire

// File: packet_launcher.sv
`timescale 1ns/100ps
`default_nettype none

`include "output_port_config.svh"

module packet_launcher (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rd_en_sel,
    input  port_pkg::credit_ctrl_t credit_ctrl,
    input  port_pkg::addr_ctrl_t   addr_ctrl,
    input  noc_pkg::dest_t         dest,
    input  logic                   done_mode,
    input  logic                   empty,
    input  port_pkg::payload_t     rd_payload,
    output logic                   read_en,
    output noc_pkg::packet_t       internal_out,
    output port_pkg::stat_t        empty_cnt
);
    import noc_pkg::*;
    import port_pkg::*;

    // credits handed back per add request
    localparam fifo_addr_t CREDIT_BLOCK = fifo_addr_t'(`OP_FREESPACE_BLOCK);
    // count after reset, remote fifo assumed empty
    localparam fifo_addr_t CREDIT_INIT  = '1;

    // free slots left in the remote fifo
    fifo_addr_t credit_cnt;
    // next remote slot to write
    fifo_addr_t fifo_addr_q;
    // read data present this cycle
    logic       valid;
    // packet built from current fields
    packet_t    packet;

    ////////////////////////////////////////
    // read request
    ////////////////////////////////////////

    // needs credit, data and the grant
    assign read_en = (credit_cnt != '0) && !empty && rd_en_sel;

    // data lands one cycle after the read
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= read_en;
        end
    end

    ////////////////////////////////////////
    // credit counter
    ////////////////////////////////////////

    // load wins, then add, then spend
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= CREDIT_INIT;
        end else if (credit_ctrl.update_freespace_en) begin
            credit_cnt <= credit_ctrl.freespace;
        end else if (credit_ctrl.add_freespace_en && read_en) begin
            // block in, one spent
            credit_cnt <= credit_cnt + CREDIT_BLOCK - fifo_addr_t'(1);
        end else if (credit_ctrl.add_freespace_en) begin
            credit_cnt <= credit_cnt + CREDIT_BLOCK;
        end else if (read_en && credit_cnt != '0) begin
            // never below zero
            credit_cnt <= credit_cnt - fifo_addr_t'(1);
        end
    end

    ////////////////////////////////////////
    // remote address
    ////////////////////////////////////////

    // steps on every read, also in done mode
    always_ff @(posedge clk) begin
        if (reset) begin
            fifo_addr_q <= '0;
        end else if (addr_ctrl.update_fifo_addr_en) begin
            fifo_addr_q <= addr_ctrl.fifo_addr;
        end else if (valid) begin
            fifo_addr_q <= fifo_addr_q + fifo_addr_t'(1);
        end
    end

    ////////////////////////////////////////
    // packet assembly
    ////////////////////////////////////////

    always_comb begin
        packet.valid     = 1'b1;
        packet.dst_leaf  = dest.dst_leaf;
        packet.dst_port  = dest.dst_port;
        packet.reserved  = '0;
        // address of this packet, counter moves after it
        packet.fifo_addr = fifo_addr_q;
        packet.payload   = rd_payload;
    end

    // zero when idle or in done mode
    assign internal_out = (valid && !done_mode) ? packet : '0;

    ////////////////////////////////////////
    // statistics
    ////////////////////////////////////////

    // idle cycles with nothing buffered
    always_ff @(posedge clk) begin
        if (reset) begin
            empty_cnt <= '0;
        end else if (empty && !done_mode) begin
            empty_cnt <= empty_cnt + stat_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: output_port.sv
`timescale 1ns/100ps
`default_nettype none

module output_port (
    input  logic                   clk,
    input  logic                   reset,
    // user stream
    input  logic                   user_valid,
    input  port_pkg::user_word_t   user_word,
    output logic                   ack,
    // network side control
    input  logic                   rd_en_sel,
    input  port_pkg::credit_ctrl_t credit_ctrl,
    input  port_pkg::addr_ctrl_t   addr_ctrl,
    input  noc_pkg::dest_t         dest,
    input  logic                   done_mode,
    // network side outputs
    output noc_pkg::packet_t       internal_out,
    output logic                   empty,
    // statistics
    output port_pkg::stat_t        full_cnt,
    output port_pkg::stat_t        empty_cnt,
    output logic                   stall
);
    import port_pkg::*;

    // packer to buffer
    logic     wr_en;
    payload_t wr_payload;
    logic     full;

    // buffer to launcher
    logic     rd_en;
    payload_t rd_payload;

    ////////////////////////////////////////
    // user side
    ////////////////////////////////////////

    user_word_packer u_packer (
        .clk        (clk),
        .reset      (reset),
        .user_valid (user_valid),
        .user_word  (user_word),
        .done_mode  (done_mode),
        .full       (full),
        .ack        (ack),
        .wr_en      (wr_en),
        .wr_payload (wr_payload),
        .full_cnt   (full_cnt),
        .stall      (stall)
    );

    // 128 payloads deep
    payload_fifo u_fifo (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_payload (wr_payload),
        .rd_en      (rd_en),
        .rd_payload (rd_payload),
        .full       (full),
        .empty      (empty)
    );

    ////////////////////////////////////////
    // network side
    ////////////////////////////////////////

    packet_launcher u_launcher (
        .clk          (clk),
        .reset        (reset),
        .rd_en_sel    (rd_en_sel),
        .credit_ctrl  (credit_ctrl),
        .addr_ctrl    (addr_ctrl),
        .dest         (dest),
        .done_mode    (done_mode),
        .empty        (empty),
        .rd_payload   (rd_payload),
        .read_en      (rd_en),
        .internal_out (internal_out),
        .empty_cnt    (empty_cnt)
    );

endmodule

`default_nettype wire

// File: tb_output_port.sv
`timescale 1ns/100ps
`default_nettype none

module tb_output_port;
    import noc_pkg::*;
    import port_pkg::*;

    // one test step, -1 in freespace or addr means no load
    typedef struct packed {
        int pairs;
        int freespace;
        int addr;
        bit add_block;
        bit sel;
        bit done;
        int n_pkts;
        bit lat;
        bit fill;
    } row_t;

    logic         clk = 1'b0;
    logic         reset = 1'b1;
    logic         user_valid;
    user_word_t   user_word;
    logic         ack;
    logic         rd_en_sel;
    credit_ctrl_t credit_ctrl;
    addr_ctrl_t   addr_ctrl;
    dest_t        dest;
    logic         done_mode;
    packet_t      internal_out;
    logic         empty;
    stat_t        full_cnt;
    stat_t        empty_cnt;
    logic         stall;

    row_t         rows [9];
    // reference model, payloads in write order and next remote address
    payload_t     exp_q [$];
    fifo_addr_t   exp_addr;
    int           seen;
    int           target;
    logic [15:0]  lfsr = 16'd33;

    output_port dut0 (.*);

    always #4 clk = ~clk;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic halt_run();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_packet(string name, packet_t got, packet_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            halt_run();
        end
    endtask

    task automatic check_stat(string name, stat_t got, stat_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            halt_run();
        end
    endtask

    task automatic check_level(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            halt_run();
        end
    endtask

    function automatic row_t make_row(int pairs, int freespace, int addr, bit add_block,
                                      bit sel, bit done, int n_pkts, bit lat, bit fill);
        return row_t'({pairs, freespace, addr, add_block, sel, done, n_pkts, lat, fill});
    endfunction

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one step per bit taken
    function automatic user_word_t next_word();
        user_word_t w;
        for (int i = 0; i < $bits(user_word_t); i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[$bits(user_word_t)-2:0], lfsr[0]};
        end
        return w;
    endfunction

    // hold the word until ack, taken at the next rising edge
    task automatic send_word(user_word_t w);
        user_valid = 1'b1;
        user_word  = w;
        while (!ack) begin
            check_level("stall", stall, !done_mode);
            @(negedge clk);
        end
        @(negedge clk);
        user_valid = 1'b0;
    endtask

    // first word goes to the low half
    task automatic send_pair();
        user_word_t lo;
        user_word_t hi;
        lo = next_word();
        hi = next_word();
        send_word(lo);
        send_word(hi);
        exp_q.push_back({hi, lo});
    endtask

    ////////////////////////////////////////
    // one table row
    ////////////////////////////////////////

    task automatic apply_row(row_t r);
        stat_t idle_snap;
        stat_t full_snap;
        // grant off while credits and address move
        rd_en_sel = 1'b0;
        done_mode = r.done;
        idle_snap = empty_cnt;
        if (r.freespace >= 0 || r.addr >= 0) begin
            credit_ctrl.update_freespace_en = (r.freespace >= 0);
            credit_ctrl.freespace = fifo_addr_t'(r.freespace);
            addr_ctrl.update_fifo_addr_en = (r.addr >= 0);
            addr_ctrl.fifo_addr = fifo_addr_t'(r.addr);
            if (r.addr >= 0) begin
                exp_addr = fifo_addr_t'(r.addr);
            end
            @(negedge clk);
            credit_ctrl = '0;
            addr_ctrl = '0;
        end
        if (r.add_block) begin
            credit_ctrl.add_freespace_en = 1'b1;
            @(negedge clk);
            credit_ctrl = '0;
        end
        rd_en_sel = r.sel;
        for (int i = 0; i < r.pairs; i++) begin
            send_pair();
        end
        if (r.lat) begin
            // pair done at edge k, packet after edge k+2
            check_level("internal_out.valid", internal_out.valid, 1'b0);
            @(negedge clk);
            check_level("internal_out.valid", internal_out.valid, 1'b0);
            @(negedge clk);
            check_level("internal_out.valid", internal_out.valid, 1'b1);
        end
        if (r.fill) begin
            // buffer full, user keeps offering
            user_valid = 1'b1;
            full_snap = full_cnt;
            repeat (4) begin
                check_level("ack", ack, 1'b0);
                check_level("stall", stall, 1'b1);
                @(negedge clk);
            end
            check_stat("full_cnt", full_cnt, full_snap + stat_t'(4));
            user_valid = 1'b0;
        end
        if (r.done) begin
            // reads go on unseen until the buffer drains
            @(negedge clk);
            while (!empty) begin
                @(negedge clk);
            end
            repeat (2) @(negedge clk);
            check_stat("empty_cnt", empty_cnt, idle_snap);
            exp_addr += fifo_addr_t'(exp_q.size());
            exp_q.delete();
        end else begin
            target += r.n_pkts;
            while (seen < target) begin
                @(negedge clk);
            end
            repeat (6) @(negedge clk);
            if (seen != target) begin
                $display("%0d packets seen where %0d were due", seen, target);
                halt_run();
            end
        end
    endtask

    ////////////////////////////////////////
    // packet monitor
    ////////////////////////////////////////

    // sampled between the rising edge and the next drive
    always begin
        packet_t want;
        @(posedge clk);
        #2;
        if (!reset) begin
            if (internal_out.valid && !done_mode) begin
                if (exp_q.size() == 0) begin
                    $display("packet with address %h came with nothing pending",
                             internal_out.fifo_addr);
                    halt_run();
                end else begin
                    want = '0;
                    want.valid     = 1'b1;
                    want.dst_leaf  = dest.dst_leaf;
                    want.dst_port  = dest.dst_port;
                    want.fifo_addr = exp_addr;
                    want.payload   = exp_q.pop_front();
                    check_packet("internal_out", internal_out, want);
                    exp_addr++;
                    seen++;
                end
            end else begin
                // idle or done mode, bus stays quiet
                check_packet("internal_out", internal_out, '0);
            end
        end
    end

    // four cycles per word plus margin
    initial begin
        int words;
        words = 0;
        #1;
        foreach (rows[i]) begin
            words += 2 * rows[i].pairs;
        end
        #((words * 4 + 600) * 8);
        $display("timeout, run still busy after %0d word slots", words);
        halt_run();
    end

    initial begin
        //                  pairs  fs  addr add sel done pkts lat fill
        rows[0] = make_row(   1,  -1,   5,  0,  1,  0,    1,  1,  0);
        rows[1] = make_row(   6,  -1,  -1,  0,  1,  0,    6,  0,  0);
        rows[2] = make_row(   5,   3,  40,  0,  1,  0,    3,  0,  0);
        rows[3] = make_row(   0,  -1,  -1,  1,  1,  0,    2,  0,  0);
        rows[4] = make_row(   4,  -1,  -1,  0,  1,  1,    0,  0,  0);
        rows[5] = make_row(   2,  -1,  -1,  0,  1,  0,    2,  0,  0);
        rows[6] = make_row( 128,  -1, 100,  0,  0,  0,    0,  0,  1);
        rows[7] = make_row(   0, 127,  -1,  0,  1,  0,  127,  0,  0);
        rows[8] = make_row(   1,  -1,  -1,  1,  1,  0,    2,  0,  0);
        user_valid  = 1'b0;
        user_word   = '0;
        rd_en_sel   = 1'b0;
        done_mode   = 1'b0;
        credit_ctrl = '0;
        addr_ctrl   = '0;
        dest        = {leaf_t'(6'h2b), port_t'(4'h9)};
        exp_addr    = '0;
        seen        = 0;
        target      = 0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        // quiet port out of reset
        check_packet("internal_out", internal_out, '0);
        check_level("ack", ack, 1'b1);
        check_level("empty", empty, 1'b1);
        check_stat("full_cnt", full_cnt, '0);
        check_stat("empty_cnt", empty_cnt, '0);
        repeat (4) @(negedge clk);
        check_stat("empty_cnt", empty_cnt, stat_t'(4));
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        if (exp_q.size() != 0) begin
            $display("%0d payloads never left the port", exp_q.size());
            halt_run();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: output_port.f
+incdir+.
noc_pkg.sv
port_pkg.sv
user_word_packer.sv
payload_fifo.sv
packet_launcher.sv
output_port.sv
tb_output_port.sv
